// File: common/multiplier_consts.svh
`ifndef MULTIPLIER_CONSTS_SVH
`define MULTIPLIER_CONSTS_SVH

// operand width of the multiplicand on the switches and of registers A and B.
`define MUL_WIDTH 8

// number of arith/shift pairs that make up one product.
`define MUL_STEPS 8

// flops in each button synchronizer chain.
`define SYNC_STAGES 2

`endif

// File: common/multiplierPkg.sv
`include "multiplier_consts.svh"

package multiplierPkg;

	// one datapath operation is executed per clock cycle.
	typedef enum logic [2:0] {
		opHold   = 3'd0, // every register keeps its value.
		opLoadB  = 3'd1, // switches go into B while A and X are cleared.
		opClearA = 3'd2, // A and X are cleared and B is left alone.
		opAdd    = 3'd3, // X:A takes X:A plus the sign-extended switches.
		opSub    = 3'd4, // X:A takes X:A minus the sign-extended switches.
		opShift  = 3'd5  // X:A:B moves right by one with X copied into the top.
	} mulOp_t;

	// sequencing states of the control unit.
	typedef enum logic [2:0] {
		stIdle  = 3'd0, // waiting for a load or a run press.
		stClear = 3'd1, // first cycle of a run that zeroes A and X.
		stArith = 3'd2, // add, subtract or hold depending on the low bit of B.
		stShift = 3'd3, // arithmetic right shift of the whole register chain.
		stHold  = 3'd4  // product is complete and stays on the display.
	} ctrlState_t;

	// register contents as seen by the control unit and the display.
	typedef struct packed {
		logic                  x; // sign extension bit that drives the LED.
		logic [`MUL_WIDTH-1:0] a; // upper byte of the product.
		logic [`MUL_WIDTH-1:0] b; // multiplier that becomes the lower product byte.
	} regView_t;

endpackage

// File: logic/buttonSync.sv
`timescale 1ns/1ps
`include "multiplier_consts.svh"

module buttonSync (
	input  logic Clk,         // board clock.
	input  logic reset,       // synchronous reset, active high.
	input  logic clearALoadB, // load button pin, low while pressed.
	input  logic run,         // run button pin, low while pressed.
	output logic loadLevel,   // high while the load button is held.
	output logic runPulse     // one cycle high for each press of run.
);

	logic [`SYNC_STAGES-1:0] loadSync; // synchronizer chain for the load button.
	logic [`SYNC_STAGES-1:0] runSync;  // synchronizer chain for the run button.
	logic                    runHeld;  // run as seen one cycle earlier.
	logic                    loadNow;  // load button after the chain.
	logic                    runNow;   // run button after the chain.

	assign loadNow = loadSync[`SYNC_STAGES-1]; // last stage of the chain is stable.
	assign runNow  = runSync[`SYNC_STAGES-1];

	always_ff @(posedge Clk) begin
		if (reset) begin
			loadSync  <= '0; // both buttons count as released.
			runSync   <= '0;
			runHeld   <= 1'b0;
			loadLevel <= 1'b0;
			runPulse  <= 1'b0;
		end else begin
			// the pins are inverted on entry so a pressed button reads as one.
			loadSync  <= {loadSync[`SYNC_STAGES-2:0], ~clearALoadB};
			runSync   <= {runSync[`SYNC_STAGES-2:0], ~run};
			runHeld   <= runNow;            // remembers the previous sample.
			loadLevel <= loadNow;           // level output lines up with the pulse.
			runPulse  <= runNow & ~runHeld; // only the press edge gives a pulse.
		end
	end

endmodule

// File: logic/hexDriver.sv
`timescale 1ns/1ps

module hexDriver (
	input  logic [3:0] nibble,  // value of one hex digit.
	output logic [6:0] segments // segments g down to a, low turns a segment on.
);

	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000; // every outer segment lit.
			4'h1: segments = 7'b1111001; // right side only.
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000; // all seven lit.
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011; // lower case b.
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001; // lower case d.
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111; // blank for an unknown input.
		endcase
	end

endmodule

// File: multiplier/controlUnit.sv
`timescale 1ns/1ps
`include "multiplier_consts.svh"

module controlUnit (
	input  logic                    Clk,       // board clock.
	input  logic                    reset,     // synchronous reset, active high.
	input  logic                    loadLevel, // load button held, already synchronized.
	input  logic                    runPulse,  // one cycle per run press.
	input  multiplierPkg::regView_t view,      // register contents from the datapath.
	output multiplierPkg::mulOp_t   op         // operation for the datapath this cycle.
);

	localparam int CountWidth = $clog2(`MUL_STEPS); // enough bits to count every step.
	localparam logic [CountWidth-1:0] LastStep = CountWidth'(`MUL_STEPS - 1);

	multiplierPkg::ctrlState_t state;         // current FSM state.
	multiplierPkg::ctrlState_t stateNext;     // state after this edge.
	logic [CountWidth-1:0]     stepCount;     // index of the pair in progress.
	logic [CountWidth-1:0]     stepCountNext; // counter value after this edge.
	logic                      lastStep;      // the pair in progress is the sign step.
	logic                      multBit;       // multiplier bit that selects add or hold.

	assign lastStep = (stepCount == LastStep); // the top bit of B carries negative weight.
	assign multBit  = view.b[0];               // bits arrive here one by one as B shifts.

	always_ff @(posedge Clk) begin
		if (reset) begin
			state     <= multiplierPkg::stIdle; // wake up waiting for a button.
			stepCount <= '0;                    // no pair in progress.
		end else begin
			state     <= stateNext;
			stepCount <= stepCountNext;
		end
	end

	always_comb begin
		stateNext     = state;                // stay put unless a branch below moves on.
		stepCountNext = stepCount;            // the counter only moves after a shift.
		op            = multiplierPkg::opHold; // registers are left alone by default.

		case (state)
			multiplierPkg::stIdle: begin
				if (loadLevel) begin
					op = multiplierPkg::opLoadB; // loading wins over a run press.
				end else if (runPulse) begin
					stateNext = multiplierPkg::stClear; // start a fresh product.
				end
			end

			multiplierPkg::stClear: begin
				op            = multiplierPkg::opClearA; // A and X start from zero.
				stepCountNext = '0;                      // first pair comes next.
				stateNext     = multiplierPkg::stArith;
			end

			multiplierPkg::stArith: begin
				if (multBit) begin
					if (lastStep) begin
						op = multiplierPkg::opSub; // the sign bit of B weighs minus 128.
					end else begin
						op = multiplierPkg::opAdd; // ordinary bits add the multiplicand.
					end
				end
				stateNext = multiplierPkg::stShift; // a zero bit just holds for a cycle.
			end

			multiplierPkg::stShift: begin
				op = multiplierPkg::opShift; // move the partial product one place right.
				if (lastStep) begin
					stateNext = multiplierPkg::stHold; // all pairs are done.
				end else begin
					stepCountNext = stepCount + CountWidth'(1);
					stateNext     = multiplierPkg::stArith;
				end
			end

			multiplierPkg::stHold: begin
				// a run held past the product gives no second pulse, so idle is safe.
				stateNext = multiplierPkg::stIdle;
			end

			default: begin
				stateNext = multiplierPkg::stIdle; // unused codes fall back to idle.
			end
		endcase
	end

endmodule

// File: multiplier/shiftDatapath.sv
`timescale 1ns/1ps
`include "multiplier_consts.svh"

module shiftDatapath (
	input  logic                    Clk,   // board clock.
	input  logic                    reset, // synchronous reset, active high.
	input  multiplierPkg::mulOp_t   op,    // operation chosen by the control unit.
	input  logic [`MUL_WIDTH-1:0]   sw,    // multiplicand, or the B value while loading.
	output multiplierPkg::regView_t view   // X, A and B for the control unit and display.
);

	localparam int SumWidth = `MUL_WIDTH + 1; // X and A together form the adder width.

	logic                  xReg;        // sign extension of the partial product.
	logic [`MUL_WIDTH-1:0] aReg;        // upper half of the partial product.
	logic [`MUL_WIDTH-1:0] bReg;        // multiplier bits, replaced by product bits.
	logic                  subtract;    // the adder works as a subtractor this cycle.
	logic [SumWidth-1:0]   swExt;       // multiplicand with its sign bit repeated.
	logic [SumWidth-1:0]   addend;      // multiplicand or its ones complement.
	logic [SumWidth-1:0]   xa;          // current X:A as one signed value.
	logic [SumWidth-1:0]   arithResult; // new X:A after an add or a subtract.

	assign subtract = (op == multiplierPkg::opSub);   // only the sign step subtracts.
	assign swExt    = {sw[`MUL_WIDTH-1], sw};         // widen the multiplicand by one bit.
	assign addend   = swExt ^ {SumWidth{subtract}};   // invert the bits for a subtract.
	assign xa       = {xReg, aReg};

	// the carry in completes the twos complement when subtracting.
	assign arithResult = xa + addend + SumWidth'(subtract);

	always_ff @(posedge Clk) begin
		if (reset) begin
			xReg <= 1'b0; // the display shows zero after reset.
			aReg <= '0;
			bReg <= '0;
		end else begin
			case (op)
				multiplierPkg::opLoadB: begin
					xReg <= 1'b0; // a new operand discards the old product.
					aReg <= '0;
					bReg <= sw;   // the switches become the multiplier.
				end

				multiplierPkg::opClearA: begin
					xReg <= 1'b0; // B is kept so a second run reuses it.
					aReg <= '0;
				end

				multiplierPkg::opAdd, multiplierPkg::opSub: begin
					{xReg, aReg} <= arithResult; // partial products never overflow nine bits.
				end

				multiplierPkg::opShift: begin
					aReg <= {xReg, aReg[`MUL_WIDTH-1:1]}; // X refills the top so the sign stays.
					bReg <= {aReg[0], bReg[`MUL_WIDTH-1:1]}; // the used multiplier bit drops out.
				end

				default: begin
					// opHold leaves every register as it is.
				end
			endcase
		end
	end

	assign view = '{x: xReg, a: aReg, b: bReg}; // registers go out as one bundle.

endmodule

// File: multiplier/eightBitMultiplier.sv
`timescale 1ns/1ps
`include "multiplier_consts.svh"

module eightBitMultiplier (
	input  logic                  Clk,         // board clock.
	input  logic                  reset,       // synchronous reset, active high.
	input  logic                  clearALoadB, // push button, low while pressed.
	input  logic                  run,         // push button, low while pressed.
	input  logic [`MUL_WIDTH-1:0] sw,          // slide switches.
	output logic                  x,           // sign bit of the product on the LED.
	output logic [6:0]            aHexU,       // upper digit of A.
	output logic [6:0]            aHexL,       // lower digit of A.
	output logic [6:0]            bHexU,       // upper digit of B.
	output logic [6:0]            bHexL        // lower digit of B.
);

	logic                    loadLevel; // high while the load button is held.
	logic                    runPulse;  // single cycle per run press.
	multiplierPkg::mulOp_t   op;        // operation for the current cycle.
	multiplierPkg::regView_t view;      // X, A and B as they stand now.

	buttonSync buttonSync_i (
		.Clk         (Clk),
		.reset       (reset),
		.clearALoadB (clearALoadB),
		.run         (run),
		.loadLevel   (loadLevel),
		.runPulse    (runPulse)
	);

	controlUnit controlUnit_i (
		.Clk       (Clk),
		.reset     (reset),
		.loadLevel (loadLevel),
		.runPulse  (runPulse),
		.view      (view),
		.op        (op)
	);

	shiftDatapath shiftDatapath_i (
		.Clk   (Clk),
		.reset (reset),
		.op    (op),
		.sw    (sw),
		.view  (view)
	);

	hexDriver aHexU_i (.nibble(view.a[`MUL_WIDTH-1 -: 4]), .segments(aHexU)); // high nibble of A.
	hexDriver aHexL_i (.nibble(view.a[3:0]), .segments(aHexL));               // low nibble of A.
	hexDriver bHexU_i (.nibble(view.b[`MUL_WIDTH-1 -: 4]), .segments(bHexU)); // high nibble of B.
	hexDriver bHexL_i (.nibble(view.b[3:0]), .segments(bHexL));               // low nibble of B.

	assign x = view.x; // the LED follows the sign extension register.

endmodule

// File: tests/multiplierTb.sv
`timescale 1ns/1ps
`include "multiplier_consts.svh"

module multiplierTb;

	localparam int ClkPeriod      = 8;                 // board clock period in ns.
	localparam int ResetCycles    = 10;                // cycles with reset held high.
	localparam int FileVectors    = 20;                // rows in the vector file.
	localparam int RandomVectors  = 20;                // vectors drawn from the seed.
	localparam int ExtraVectors   = 4;                 // long hold and second press, weighted.
	localparam int SettleCycles   = `SYNC_STAGES + 2;  // let the load level drain.
	localparam int ProductWait    = 24;                // product is final well before this.
	localparam int WatchdogCycles = (FileVectors + RandomVectors + ExtraVectors) * 40 + 200;

	logic                  Clk;         // DUT clock.
	logic                  reset;       // synchronous reset, active high.
	logic                  clearALoadB; // load button, low while pressed.
	logic                  run;         // run button, low while pressed.
	logic [`MUL_WIDTH-1:0] sw;          // slide switches.
	logic                  x;           // sign LED.
	logic [6:0]            aHexU;       // digits of A.
	logic [6:0]            aHexL;
	logic [6:0]            bHexU;       // digits of B.
	logic [6:0]            bHexL;

	logic [7:0]  testData [0:FileVectors*5-1]; // five bytes per vector.
	int          errorCount;                   // mismatches seen so far.
	int          checkCount;                   // comparisons made so far.
	int          seed;                         // state of the random sequence.
	int          vec;                          // vector index.
	int          dataFile;                     // handle used to see that the file exists.
	logic [7:0]  bVal;                         // multiplier loaded into B.
	logic [7:0]  mVal;                         // multiplicand on the switches.
	logic [15:0] product;                      // expected A:B.
	logic [15:0] second;                       // expected A:B of a repeated press.

	eightBitMultiplier eightBitMultiplier_i (
		.Clk         (Clk),
		.reset       (reset),
		.clearALoadB (clearALoadB),
		.run         (run),
		.sw          (sw),
		.x           (x),
		.aHexU       (aHexU),
		.aHexL       (aHexL),
		.bHexU       (bHexU),
		.bHexL       (bHexL)
	);

	always #(ClkPeriod/2) Clk = ~Clk; // free running clock.

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// bit 4 of the result flags a pattern that is not a hex digit.
	function automatic logic [4:0] decodeSegments(input logic [6:0] segments);
		logic [4:0] digit;
		case (segments)
			7'b1000000: digit = 5'h00;
			7'b1111001: digit = 5'h01;
			7'b0100100: digit = 5'h02;
			7'b0110000: digit = 5'h03;
			7'b0011001: digit = 5'h04;
			7'b0010010: digit = 5'h05;
			7'b0000010: digit = 5'h06;
			7'b1111000: digit = 5'h07;
			7'b0000000: digit = 5'h08;
			7'b0010000: digit = 5'h09;
			7'b0001000: digit = 5'h0A;
			7'b0000011: digit = 5'h0B;
			7'b1000110: digit = 5'h0C;
			7'b0100001: digit = 5'h0D;
			7'b0000110: digit = 5'h0E;
			7'b0001110: digit = 5'h0F;
			default:    digit = 5'h10;
		endcase
		return digit;
	endfunction

	// signed product of two bytes, worked out in full integer width.
	function automatic logic [15:0] signedProduct(input logic [7:0] m, input logic [7:0] b);
		int p;
		p = int'($signed(m)) * int'($signed(b));
		return p[15:0];
	endfunction

	task automatic checkDisplay(input logic [7:0] a, input logic [7:0] b, input logic xBit);
		checkValue("aHexU digit", 32'({1'b0, a[7:4]}), 32'(decodeSegments(aHexU)));
		checkValue("aHexL digit", 32'({1'b0, a[3:0]}), 32'(decodeSegments(aHexL)));
		checkValue("bHexU digit", 32'({1'b0, b[7:4]}), 32'(decodeSegments(bHexU)));
		checkValue("bHexL digit", 32'({1'b0, b[3:0]}), 32'(decodeSegments(bHexL)));
		checkValue("x", 32'(xBit), 32'(x));
	endtask

	// inputs change one ns after the edge, where outputs are also stable.
	task automatic waitCycles(input int count);
		repeat (count) @(posedge Clk);
		#1;
	endtask

	task automatic loadB(input logic [7:0] value);
		sw          = value;
		clearALoadB = 1'b0;         // press the load button.
		waitCycles(4);
		clearALoadB = 1'b1;
		waitCycles(SettleCycles);   // switches must stay put until loading stops.
		checkDisplay(8'h00, value, 1'b0);
	endtask

	task automatic pressRun(input int holdCycles);
		run = 1'b0;
		waitCycles(holdCycles);
		run = 1'b1;
		waitCycles(ProductWait);
	endtask

	task automatic multiplyAndCheck(input logic [7:0] b, input logic [7:0] m,
			input logic [7:0] expA, input logic [7:0] expB, input logic expX);
		loadB(b);
		sw = m; // multiplicand goes on the switches after the load.
		pressRun(4);
		checkDisplay(expA, expB, expX);
	endtask

	initial begin
		Clk         = 1'b0;
		reset       = 1'b1;
		clearALoadB = 1'b1; // both buttons released.
		run         = 1'b1;
		sw          = '0;
		errorCount  = 0;
		checkCount  = 0;
		seed        = 32'haf4c_565c;

		dataFile = $fopen("tests/multiplier_testdata.txt", "r");
		if (dataFile == 0) begin
			errorCount++;
			$display("the vector file tests/multiplier_testdata.txt could not be opened");
		end else begin
			$fclose(dataFile);
		end
		$readmemh("tests/multiplier_testdata.txt", testData);

		repeat (ResetCycles) @(posedge Clk);
		#1;
		reset = 1'b0;
		waitCycles(2);
		checkDisplay(8'h00, 8'h00, 1'b0); // everything reads zero out of reset.

		for (vec = 0; vec < FileVectors; vec++) begin
			multiplyAndCheck(testData[vec*5], testData[vec*5+1], testData[vec*5+2],
				testData[vec*5+3], testData[vec*5+4][0]);
		end

		for (vec = 0; vec < RandomVectors; vec++) begin
			bVal    = 8'($random(seed));
			mVal    = 8'($random(seed));
			product = signedProduct(mVal, bVal);
			multiplyAndCheck(bVal, mVal, product[15:8], product[7:0], product[15]);
		end

		// a run held far past the product must not start another one.
		loadB(8'hD3);
		mVal    = 8'h6B;
		sw      = mVal;
		product = signedProduct(mVal, 8'hD3);
		run     = 1'b0;
		waitCycles(60);
		checkDisplay(product[15:8], product[7:0], product[15]);
		run = 1'b1;
		waitCycles(ProductWait);
		checkDisplay(product[15:8], product[7:0], product[15]);

		// pressing again reuses B, which now holds the low product byte.
		second = signedProduct(mVal, product[7:0]);
		pressRun(4);
		checkDisplay(second[15:8], second[7:0], second[15]);

		$display("%0d checks done, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("watchdog expired after %0d cycles before the test finished", WatchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tests/multiplier_testdata.txt
// columns: B value, multiplicand on the switches, expected A, expected B, expected X.
// every column is a hex byte; A:B is the signed product of multiplicand and B.
FF FF 00 01 00
FF 01 FF FF 01
01 01 00 01 00
01 FF FF FF 01
80 80 40 00 00
7F 80 C0 80 01
00 5A 00 00 00
03 07 00 15 00
0C F6 FF 88 01
80 7F C0 80 01
7F 7F 3F 01 00
C8 19 FA 88 01
2D B3 F2 77 01
E7 E7 02 71 00
64 64 27 10 00
01 80 FF 80 01
FE 02 FF FC 01
55 AA E3 72 01
00 00 00 00 00
FF 80 00 80 00

// File: filelist.f
+incdir+common
common/multiplierPkg.sv
logic/buttonSync.sv
logic/hexDriver.sv
multiplier/controlUnit.sv
multiplier/shiftDatapath.sv
multiplier/eightBitMultiplier.sv
tests/multiplierTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = multiplierTb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJDIR)
